// ==== include/iv_config.svh ====
/* Widths, block size and MAC constants for the integrity verifier.
   Address plus counter width must equal the data width (one header word).
   Block word count must be at least 2. */
`ifndef IV_CONFIG_SVH
`define IV_CONFIG_SVH

// Bus and field widths
`define IV_DATA_WIDTH 32
`define IV_ADDR_WIDTH 16
`define IV_LEAF_WIDTH 12
`define IV_COUNTER_WIDTH 16

// Words per block, MAC word excluded
`define IV_BLOCK_WORDS 4

// Keyed mixing constants
`define IV_MAC_KEY 32'h5E7A2A9D
`define IV_MAC_ROUND 32'h9E3779B9

`endif

// ==== design/ivTypesPkg.sv ====
/* Vector types for the integrity verifier datapath.
   Widths come from the config header. */
`include "iv_config.svh"

package ivTypesPkg;

	// ----------------------------------------
	// Datapath words
	// ----------------------------------------

	// One word on any store or load stream
	typedef logic [`IV_DATA_WIDTH-1:0] dataWord_t;

	// MAC is exactly one bus word
	typedef logic [`IV_DATA_WIDTH-1:0] macWord_t;

	// ----------------------------------------
	// Command fields
	// ----------------------------------------

	// Physical block address
	typedef logic [`IV_ADDR_WIDTH-1:0] pAddr_t;

	// Path label in the tree
	typedef logic [`IV_LEAF_WIDTH-1:0] leaf_t;

	// Per-block write counter
	typedef logic [`IV_COUNTER_WIDTH-1:0] counter_t;

endpackage

// ==== design/ivCommandPkg.sv ====
/* Command, job and sequencing types of the integrity verifier.
   The same command struct is used on the frontend and the backend side. */
`include "iv_config.svh"

package ivCommandPkg;
	import ivTypesPkg::*;

	// ----------------------------------------
	// Frontend and backend command
	// ----------------------------------------

	// Update and Append are writes, the others reads
	typedef enum logic [1:0] {
		Read = 2'd0,
		Update = 2'd1,
		Append = 2'd2,
		ReadRemove = 2'd3
	} ivOp_t;

	typedef struct packed {
		ivOp_t op;
		pAddr_t pAddr;
		leaf_t currentLeaf;
		leaf_t remappedLeaf;
	} ivCommand_t;

	// ----------------------------------------
	// Job for store and load paths
	// ----------------------------------------

	// Remapped counter travels along, header uses the current one
	typedef struct packed {
		pAddr_t pAddr;
		counter_t currentCounter;
		counter_t remappedCounter;
	} ivJob_t;

	// Decoder FSM
	typedef enum logic [2:0] {
		Idle,
		StoreBusy,
		WriteCommand,
		ReadCommand,
		LoadBusy
	} decodeState_t;

endpackage

// ==== design/macEngine.sv ====
/* Word-serial keyed MAC. Not a cryptographic hash.
   New words are refused while a finished digest waits to be taken. */
`timescale 1ns/1ps
`include "iv_config.svh"

module macEngine (
	input logic Clock,
	input logic reset,
	input ivTypesPkg::dataWord_t macData,
	input logic macLast,
	input logic macValid,
	output logic macReady,
	output ivTypesPkg::macWord_t digest,
	output logic digestValid,
	input logic digestReady
);
	import ivTypesPkg::*;

	localparam int MacWidth = $bits(macWord_t);

	// Running digest, also the presented result
	macWord_t state;
	macWord_t mixed;
	macWord_t nextDigest;
	logic wordAccept;
	logic digestTaken;

	// ----------------------------------------
	// Mixing step
	// ----------------------------------------

	// Absorb by XOR
	assign mixed = state ^ macData;

	// Rotate left by 5, then add round constant
	assign nextDigest = {mixed[MacWidth-6:0], mixed[MacWidth-1:MacWidth-5]} + `IV_MAC_ROUND;

	// ----------------------------------------
	// Handshakes
	// ----------------------------------------

	assign macReady = !digestValid;
	assign wordAccept = macValid && macReady;
	assign digestTaken = digestValid && digestReady;
	assign digest = state;

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= `IV_MAC_KEY;
			digestValid <= 1'b0;
		end else if (digestTaken) begin
			// Fresh key for the next message
			state <= `IV_MAC_KEY;
			digestValid <= 1'b0;
		end else if (wordAccept) begin
			state <= nextDigest;
			digestValid <= macLast;
		end
	end

	// Users must hold off new words until the digest is taken
	assert property (@(posedge Clock) disable iff (reset)
		macValid |-> !digestValid)
		else $error("macEngine: word offered while digest pending");

endmodule

// ==== design/commandDecoder.sv ====
/* Accepts one frontend command at a time and sequences its job.
   Writes send the backend command after the MAC word, reads before the load. */
`timescale 1ns/1ps

module commandDecoder (
	input logic Clock,
	input logic reset,
	input ivCommandPkg::ivCommand_t FECommand,
	input ivTypesPkg::counter_t FECurrentCounter,
	input ivTypesPkg::counter_t FERemappedCounter,
	input logic FECommandValid,
	output logic FECommandReady,
	output ivCommandPkg::ivCommand_t BECommand,
	output logic BECommandValid,
	input logic BECommandReady,
	output ivCommandPkg::ivJob_t storeJob,
	output logic storeJobValid,
	input logic storeJobReady,
	input logic storeDone,
	output ivCommandPkg::ivJob_t loadJob,
	output logic loadJobValid,
	input logic loadJobReady,
	input logic loadDone
);
	import ivCommandPkg::*;

	decodeState_t state;
	decodeState_t nextState;

	// Held command and job
	ivCommand_t commandReg;
	ivJob_t jobReg;

	// Ready mirrors Idle, low out of reset
	logic commandReady;
	// Job offered and not yet taken
	logic jobPending;

	logic commandAccept;
	logic isWrite;
	logic beTransfer;
	logic jobTaken;

	// ----------------------------------------
	// Frontend side
	// ----------------------------------------

	assign FECommandReady = commandReady;
	assign commandAccept = FECommandValid && commandReady;
	assign isWrite = FECommand.op inside {Update, Append};

	always_ff @(posedge Clock) begin
		if (commandAccept) begin
			commandReg <= FECommand;
			jobReg.pAddr <= FECommand.pAddr;
			jobReg.currentCounter <= FECurrentCounter;
			jobReg.remappedCounter <= FERemappedCounter;
		end
	end

	// ----------------------------------------
	// FSM
	// ----------------------------------------

	assign beTransfer = BECommandValid && BECommandReady;

	always_comb begin
		nextState = state;
		case (state)
			Idle:
				if (commandAccept)
					nextState = isWrite ? StoreBusy : ReadCommand;
			StoreBusy:
				if (storeDone)
					nextState = WriteCommand;
			WriteCommand:
				if (beTransfer)
					nextState = Idle;
			ReadCommand:
				if (beTransfer)
					nextState = LoadBusy;
			LoadBusy:
				if (loadDone)
					nextState = Idle;
			default:
				nextState = Idle;
		endcase
	end

	assign jobTaken = (storeJobValid && storeJobReady) || (loadJobValid && loadJobReady);

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= Idle;
			commandReady <= 1'b0;
			jobPending <= 1'b0;
		end else begin
			state <= nextState;
			commandReady <= (nextState == Idle);
			// Write job right after acceptance, read job after the backend command
			if ((commandAccept && isWrite) || (state == ReadCommand && beTransfer))
				jobPending <= 1'b1;
			else if (jobTaken)
				jobPending <= 1'b0;
		end
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------

	assign BECommand = commandReg;
	assign BECommandValid = (state == WriteCommand) || (state == ReadCommand);

	assign storeJob = jobReg;
	assign storeJobValid = (state == StoreBusy) && jobPending;
	assign loadJob = jobReg;
	assign loadJobValid = (state == LoadBusy) && jobPending;

	// Backend command must not change under back-pressure
	assert property (@(posedge Clock) disable iff (reset)
		BECommandValid && !BECommandReady |=> BECommandValid && $stable(BECommand))
		else $error("commandDecoder: BECommand changed while stalled");

endmodule

// ==== design/storeSequencer.sv ====
/* Write path. Header and block go to the MAC, block and MAC word to the backend.
   A block word moves only when backend and MAC both accept it. */
`timescale 1ns/1ps
`include "iv_config.svh"

module storeSequencer (
	input logic Clock,
	input logic reset,
	input ivCommandPkg::ivJob_t storeJob,
	input logic storeJobValid,
	output logic storeJobReady,
	output logic storeDone,
	input ivTypesPkg::dataWord_t FEStoreData,
	input logic FEStoreValid,
	output logic FEStoreReady,
	output ivTypesPkg::dataWord_t BEStoreData,
	output logic BEStoreValid,
	input logic BEStoreReady
);
	import ivTypesPkg::*;

	typedef enum logic [1:0] {
		StoreIdle,
		StoreHeader,
		StoreBlock,
		StoreMac
	} storePhase_t;

	localparam int CountWidth = $clog2(`IV_BLOCK_WORDS);

	storePhase_t phase;
	logic [CountWidth-1:0] wordCount;
	dataWord_t headerWord;

	// MAC engine link
	dataWord_t macData;
	logic macLast;
	logic macValid;
	logic macReady;
	macWord_t digest;
	logic digestValid;
	logic digestReady;

	logic jobAccept;
	logic headerTaken;
	logic blockTransfer;
	logic macTransfer;
	logic lastWord;

	// ----------------------------------------
	// Job intake
	// ----------------------------------------

	assign storeJobReady = (phase == StoreIdle);
	assign jobAccept = storeJobValid && storeJobReady;

	// Header is address over current counter
	always_ff @(posedge Clock) begin
		if (jobAccept)
			headerWord <= {storeJob.pAddr, storeJob.currentCounter};
	end

	// ----------------------------------------
	// Stream gating
	// ----------------------------------------

	assign lastWord = (wordCount == CountWidth'(`IV_BLOCK_WORDS - 1));

	assign macData = (phase == StoreHeader) ? headerWord : FEStoreData;
	assign macValid = (phase == StoreHeader) ||
		((phase == StoreBlock) && FEStoreValid && BEStoreReady);
	assign macLast = (phase == StoreBlock) && lastWord;

	// Frontend word needs room on both sides
	assign FEStoreReady = (phase == StoreBlock) && BEStoreReady && macReady;

	// Block words pass through, then the digest
	assign BEStoreData = (phase == StoreMac) ? digest : FEStoreData;
	assign BEStoreValid = ((phase == StoreBlock) && FEStoreValid && macReady) ||
		((phase == StoreMac) && digestValid);
	assign digestReady = (phase == StoreMac) && BEStoreReady;

	assign headerTaken = (phase == StoreHeader) && macReady;
	assign blockTransfer = FEStoreValid && FEStoreReady;
	assign macTransfer = digestValid && digestReady;
	assign storeDone = macTransfer;

	// ----------------------------------------
	// Phase FSM
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			phase <= StoreIdle;
			wordCount <= '0;
		end else begin
			case (phase)
				StoreIdle:
					if (jobAccept)
						phase <= StoreHeader;
				StoreHeader:
					if (headerTaken)
						phase <= StoreBlock;
				StoreBlock:
					if (blockTransfer) begin
						wordCount <= lastWord ? '0 : wordCount + CountWidth'(1);
						if (lastWord)
							phase <= StoreMac;
					end
				StoreMac:
					if (macTransfer)
						phase <= StoreIdle;
				default:
					phase <= StoreIdle;
			endcase
		end
	end

	macEngine mac (.*);

endmodule

// ==== design/loadChecker.sv ====
/* Read path. Block words go to the frontend, the trailing MAC word is kept back
   and checked against the recomputed digest. IntegrityError clears only on reset. */
`timescale 1ns/1ps
`include "iv_config.svh"

module loadChecker (
	input logic Clock,
	input logic reset,
	input ivCommandPkg::ivJob_t loadJob,
	input logic loadJobValid,
	output logic loadJobReady,
	output logic loadDone,
	input ivTypesPkg::dataWord_t BELoadData,
	input logic BELoadValid,
	output logic BELoadReady,
	output ivTypesPkg::dataWord_t FELoadData,
	output logic FELoadValid,
	input logic FELoadReady,
	output logic ReadPass,
	output logic ReadResultValid,
	input logic ReadResultReady,
	output logic IntegrityError
);
	import ivTypesPkg::*;

	typedef enum logic [2:0] {
		LoadIdle,
		LoadHeader,
		LoadBlock,
		LoadMac,
		LoadResult
	} loadPhase_t;

	localparam int CountWidth = $clog2(`IV_BLOCK_WORDS);

	loadPhase_t phase;
	logic [CountWidth-1:0] wordCount;
	dataWord_t headerWord;
	logic passReg;

	// MAC engine link
	dataWord_t macData;
	logic macLast;
	logic macValid;
	logic macReady;
	macWord_t digest;
	logic digestValid;
	logic digestReady;

	logic jobAccept;
	logic headerTaken;
	logic blockTransfer;
	logic macCapture;
	logic lastWord;

	// ----------------------------------------
	// Job intake
	// ----------------------------------------

	assign loadJobReady = (phase == LoadIdle);
	assign jobAccept = loadJobValid && loadJobReady;

	always_ff @(posedge Clock) begin
		if (jobAccept)
			headerWord <= {loadJob.pAddr, loadJob.currentCounter};
	end

	// ----------------------------------------
	// Stream gating
	// ----------------------------------------

	assign lastWord = (wordCount == CountWidth'(`IV_BLOCK_WORDS - 1));

	// Header first, then each forwarded word
	assign macData = (phase == LoadHeader) ? headerWord : BELoadData;
	assign macValid = (phase == LoadHeader) ||
		((phase == LoadBlock) && BELoadValid && FELoadReady);
	assign macLast = (phase == LoadBlock) && lastWord;

	assign FELoadData = BELoadData;
	assign FELoadValid = (phase == LoadBlock) && BELoadValid && macReady;

	// MAC word is pulled only once the digest is there to compare
	assign BELoadReady = ((phase == LoadBlock) && FELoadReady && macReady) ||
		((phase == LoadMac) && digestValid);

	assign headerTaken = (phase == LoadHeader) && macReady;
	assign blockTransfer = (phase == LoadBlock) && BELoadValid && BELoadReady;
	assign macCapture = (phase == LoadMac) && BELoadValid && digestValid;
	assign digestReady = macCapture;

	// ----------------------------------------
	// Result
	// ----------------------------------------

	assign ReadPass = passReg;
	assign ReadResultValid = (phase == LoadResult);
	assign loadDone = ReadResultValid && ReadResultReady;

	always_ff @(posedge Clock) begin
		if (macCapture)
			passReg <= (BELoadData == digest);
	end

	// Sticky mismatch flag
	always_ff @(posedge Clock) begin
		if (reset)
			IntegrityError <= 1'b0;
		else if (macCapture && (BELoadData != digest))
			IntegrityError <= 1'b1;
	end

	// ----------------------------------------
	// Phase FSM
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			phase <= LoadIdle;
			wordCount <= '0;
		end else begin
			case (phase)
				LoadIdle:
					if (jobAccept)
						phase <= LoadHeader;
				LoadHeader:
					if (headerTaken)
						phase <= LoadBlock;
				LoadBlock:
					if (blockTransfer) begin
						wordCount <= lastWord ? '0 : wordCount + CountWidth'(1);
						if (lastWord)
							phase <= LoadMac;
					end
				LoadMac:
					if (macCapture)
						phase <= LoadResult;
				LoadResult:
					if (loadDone)
						phase <= LoadIdle;
				default:
					phase <= LoadIdle;
			endcase
		end
	end

	macEngine mac (.*);

endmodule

// ==== design/integrityVerifier.sv ====
/* Integrity verifier between an ORAM frontend and backend.
   Every stream is valid/ready. One command is in flight at a time. */
`timescale 1ns/1ps

module integrityVerifier (
	input logic Clock,
	input logic reset,

	// Frontend command
	input ivCommandPkg::ivCommand_t FECommand,
	input ivTypesPkg::counter_t FECurrentCounter,
	input ivTypesPkg::counter_t FERemappedCounter,
	input logic FECommandValid,
	output logic FECommandReady,

	// Frontend store and load
	input ivTypesPkg::dataWord_t FEStoreData,
	input logic FEStoreValid,
	output logic FEStoreReady,
	output ivTypesPkg::dataWord_t FELoadData,
	output logic FELoadValid,
	input logic FELoadReady,

	// Backend command
	output ivCommandPkg::ivCommand_t BECommand,
	output logic BECommandValid,
	input logic BECommandReady,

	// Backend store and load, block then MAC word
	output ivTypesPkg::dataWord_t BEStoreData,
	output logic BEStoreValid,
	input logic BEStoreReady,
	input ivTypesPkg::dataWord_t BELoadData,
	input logic BELoadValid,
	output logic BELoadReady,

	// Per-read result and sticky error
	output logic ReadPass,
	output logic ReadResultValid,
	input logic ReadResultReady,
	output logic IntegrityError
);
	import ivCommandPkg::*;

	// ----------------------------------------
	// Decoder to store path
	// ----------------------------------------

	ivJob_t storeJob;
	logic storeJobValid;
	logic storeJobReady;
	logic storeDone;

	// ----------------------------------------
	// Decoder to load path
	// ----------------------------------------

	ivJob_t loadJob;
	logic loadJobValid;
	logic loadJobReady;
	logic loadDone;

	// Port names match the nets above
	commandDecoder decoder (.*);

	storeSequencer storePath (.*);

	loadChecker loadPath (.*);

endmodule

// ==== tests/tbIntegrityVerifier.sv ====
/* Testbench for the integrity verifier. Cases come from tests/iv_cases.txt.
   Reads must target an address that an earlier case wrote.
   A set tamper flag flips bit 0 of the MAC word that the backend model returns. */
`timescale 1ns/1ps
`include "iv_config.svh"

module tbIntegrityVerifier;
	import ivTypesPkg::*;
	import ivCommandPkg::*;

	localparam int BlockWords = `IV_BLOCK_WORDS;
	localparam int DriveDelay = 1;
	localparam int TimeoutCycles = 300;

	typedef dataWord_t [BlockWords-1:0] block_t;

	// Backend memory entry
	typedef struct packed {
		block_t block;
		macWord_t mac;
	} storedEntry_t;

	logic Clock;
	logic reset;
	ivCommand_t FECommand;
	counter_t FECurrentCounter;
	counter_t FERemappedCounter;
	logic FECommandValid;
	logic FECommandReady;
	dataWord_t FEStoreData;
	logic FEStoreValid;
	logic FEStoreReady;
	dataWord_t FELoadData;
	logic FELoadValid;
	logic FELoadReady;
	ivCommand_t BECommand;
	logic BECommandValid;
	logic BECommandReady;
	dataWord_t BEStoreData;
	logic BEStoreValid;
	logic BEStoreReady;
	dataWord_t BELoadData;
	logic BELoadValid;
	logic BELoadReady;
	logic ReadPass;
	logic ReadResultValid;
	logic ReadResultReady;
	logic IntegrityError;

	// Backend model keyed by address
	storedEntry_t backendMemory [pAddr_t];
	// Sticky flag as the model predicts it
	logic errorExpected;

	integrityVerifier i_dut (.*);

	always #50 Clock = ~Clock;

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic reportFailure(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string what, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			reportFailure($sformatf("[ERROR] %0t: %s mismatch, got %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	// Ready high about three cycles in four
	function automatic logic randomReady();
		return ($urandom % 4) != 0;
	endfunction

	// Header word, then each block word
	function automatic macWord_t expectedMac(input pAddr_t addr, input counter_t counter,
		input block_t block);
		macWord_t digest;
		dataWord_t word;
		digest = `IV_MAC_KEY;
		for (int i = 0; i <= BlockWords; i++) begin
			word = (i == 0) ? {addr, counter} : block[i-1];
			digest = digest ^ word;
			digest = {digest[26:0], digest[31:27]} + `IV_MAC_ROUND;
		end
		return digest;
	endfunction

	// Hold the command valid until the decoder takes it
	task automatic sendCommand(input ivCommand_t command, input counter_t current,
		input counter_t remapped);
		int cycles;
		logic accepted;
		FECommand = command;
		FECurrentCounter = current;
		FERemappedCounter = remapped;
		FECommandValid = 1'b1;
		accepted = 1'b0;
		cycles = 0;
		while (!accepted) begin
			@(negedge Clock);
			accepted = FECommandReady;
			cycles++;
			if (!accepted && cycles > TimeoutCycles)
				reportFailure("Timeout: the frontend command was never accepted");
			@(posedge Clock);
			#DriveDelay;
		end
		FECommandValid = 1'b0;
	endtask

	// ----------------------------------------
	// Write path
	// ----------------------------------------

	task automatic runWrite(input ivCommand_t command, input counter_t current,
		input counter_t remapped, input block_t block);
		int cycles;
		int feIndex;
		int beIndex;
		logic commandSeen;
		storedEntry_t entry;
		macWord_t macExpected;
		macExpected = expectedMac(command.pAddr, current, block);
		sendCommand(command, current, remapped);
		feIndex = 0;
		beIndex = 0;
		commandSeen = 1'b0;
		cycles = 0;
		while (!commandSeen) begin
			FEStoreValid = (feIndex < BlockWords);
			FEStoreData = (feIndex < BlockWords) ? block[feIndex] : '0;
			BEStoreReady = randomReady();
			BECommandReady = randomReady();
			@(negedge Clock);
			// Command only after block and MAC word
			if (BECommandValid && BECommandReady) begin
				checkValue("words stored before backend command", beIndex, BlockWords + 1);
				checkValue("backend write command", BECommand, command);
				commandSeen = 1'b1;
			end
			if (FEStoreValid && FEStoreReady)
				feIndex++;
			if (BEStoreValid && BEStoreReady) begin
				if (beIndex < BlockWords) begin
					checkValue("backend store word", BEStoreData, block[beIndex]);
					entry.block[beIndex] = BEStoreData;
				end else if (beIndex == BlockWords) begin
					checkValue("backend MAC word", BEStoreData, macExpected);
					entry.mac = BEStoreData;
				end else begin
					reportFailure("The backend store stream carried more than one MAC word");
				end
				beIndex++;
			end
			if (FELoadValid || ReadResultValid || BELoadReady)
				reportFailure("The read path became active during a write");
			cycles++;
			if (!commandSeen && cycles > TimeoutCycles)
				reportFailure("Timeout: the write never reached the backend command");
			@(posedge Clock);
			#DriveDelay;
		end
		FEStoreValid = 1'b0;
		BEStoreReady = 1'b0;
		BECommandReady = 1'b0;
		backendMemory[command.pAddr] = entry;
	endtask

	// ----------------------------------------
	// Read path
	// ----------------------------------------

	task automatic runRead(input ivCommand_t command, input counter_t current,
		input counter_t remapped, input block_t fileBlock, input logic tamper);
		int cycles;
		int feIndex;
		int beIndex;
		logic commandSeen;
		logic resultSeen;
		logic passExpected;
		storedEntry_t entry;
		macWord_t returnedMac;
		if (!backendMemory.exists(command.pAddr))
			reportFailure("A case reads an address that no earlier case wrote");
		entry = backendMemory[command.pAddr];
		returnedMac = entry.mac ^ {31'd0, tamper};
		passExpected = (returnedMac == expectedMac(command.pAddr, current, entry.block));
		sendCommand(command, current, remapped);
		feIndex = 0;
		beIndex = 0;
		commandSeen = 1'b0;
		resultSeen = 1'b0;
		cycles = 0;
		while (!resultSeen) begin
			BECommandReady = randomReady();
			FELoadReady = randomReady();
			ReadResultReady = randomReady();
			// Block words, then the MAC word
			BELoadValid = commandSeen && (beIndex <= BlockWords);
			BELoadData = (beIndex < BlockWords) ? entry.block[beIndex] :
				(beIndex == BlockWords) ? returnedMac : '0;
			@(negedge Clock);
			if (BELoadReady && !commandSeen)
				reportFailure("Backend load data was requested before the backend command");
			if (BECommandValid && BECommandReady) begin
				checkValue("backend read command", BECommand, command);
				commandSeen = 1'b1;
			end
			if (FELoadValid && FELoadReady) begin
				if (feIndex >= BlockWords)
					reportFailure("The frontend received more than one block, MAC word leaked");
				checkValue("frontend load word", FELoadData, fileBlock[feIndex]);
				feIndex++;
			end
			if (BELoadValid && BELoadReady)
				beIndex++;
			if (ReadResultValid && ReadResultReady) begin
				checkValue("words forwarded before result", feIndex, BlockWords);
				checkValue("MAC words consumed before result", beIndex, BlockWords + 1);
				checkValue("ReadPass", ReadPass, passExpected);
				resultSeen = 1'b1;
			end
			if (BEStoreValid || FEStoreReady)
				reportFailure("The write path became active during a read");
			cycles++;
			if (!resultSeen && cycles > TimeoutCycles)
				reportFailure("Timeout: the read never produced a result");
			@(posedge Clock);
			#DriveDelay;
		end
		BELoadValid = 1'b0;
		BECommandReady = 1'b0;
		FELoadReady = 1'b0;
		ReadResultReady = 1'b0;
		if (!passExpected)
			errorExpected = 1'b1;
		if (command.op == ReadRemove)
			backendMemory.delete(command.pAddr);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		int fd;
		int fields;
		int caseCount;
		string lineText;
		logic [31:0] opValue;
		logic [31:0] addrValue;
		logic [31:0] currentLeaf;
		logic [31:0] remappedLeaf;
		logic [31:0] currentCounter;
		logic [31:0] remappedCounter;
		logic [31:0] tamperValue;
		block_t block;
		ivCommand_t command;

		void'($urandom(26));
		Clock = 1'b0;
		reset = 1'b1;
		FECommand = '0;
		FECurrentCounter = '0;
		FERemappedCounter = '0;
		FECommandValid = 1'b0;
		FEStoreData = '0;
		FEStoreValid = 1'b0;
		FELoadReady = 1'b0;
		BECommandReady = 1'b0;
		BEStoreReady = 1'b0;
		BELoadData = '0;
		BELoadValid = 1'b0;
		ReadResultReady = 1'b0;
		errorExpected = 1'b0;
		caseCount = 0;

		repeat (5) @(posedge Clock);
		#DriveDelay;
		reset = 1'b0;
		@(posedge Clock);
		@(negedge Clock);
		checkValue("valid outputs and IntegrityError after reset",
			{BECommandValid, BEStoreValid, FELoadValid, ReadResultValid, IntegrityError}, '0);
		@(posedge Clock);
		#DriveDelay;

		fd = $fopen("tests/iv_cases.txt", "r");
		if (fd == 0)
			reportFailure("Could not open tests/iv_cases.txt");
		while (!$feof(fd)) begin
			lineText = "";
			void'($fgets(lineText, fd));
			// Comment and blank lines yield no fields
			fields = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h", opValue, addrValue,
				currentLeaf, remappedLeaf, currentCounter, remappedCounter,
				block[0], block[1], block[2], block[3], tamperValue);
			if (fields == 11) begin
				command.op = ivOp_t'(opValue[1:0]);
				command.pAddr = addrValue[15:0];
				command.currentLeaf = currentLeaf[11:0];
				command.remappedLeaf = remappedLeaf[11:0];
				if (command.op inside {Update, Append})
					runWrite(command, currentCounter[15:0], remappedCounter[15:0], block);
				else
					runRead(command, currentCounter[15:0], remappedCounter[15:0], block,
						tamperValue[0]);
				checkValue("IntegrityError", IntegrityError, errorExpected);
				caseCount++;
			end
		end
		$fclose(fd);

		if (caseCount == 0) begin
			reportFailure("No cases were found in tests/iv_cases.txt");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// ==== tests/iv_cases.txt ====
# op addr curLeaf remapLeaf curCtr remapCtr d0 d1 d2 d3 tamper (hex; op 0 Read 1 Update 2 Append 3 ReadRemove)
# writes give the block to store, reads the block expected back; tamper flips a MAC bit on that read
2 0010 0a1 3f2 0001 0002 11111111 22222222 33333333 44444444 0
2 0020 123 456 0001 0002 deadbeef 01234567 89abcdef fedcba98 0
0 0010 3f2 155 0001 0002 11111111 22222222 33333333 44444444 0
1 0010 155 7e0 0002 0003 cafef00d 0badc0de 13579bdf 2468ace0 0
0 0010 7e0 001 0002 0003 cafef00d 0badc0de 13579bdf 2468ace0 0
0 0020 456 abc 0001 0002 deadbeef 01234567 89abcdef fedcba98 0
2 0030 fff 000 0005 0006 a5a5a5a5 5a5a5a5a 00000000 ffffffff 0
0 0030 000 800 0005 0006 a5a5a5a5 5a5a5a5a 00000000 ffffffff 1
0 0010 001 002 0002 0003 cafef00d 0badc0de 13579bdf 2468ace0 0
3 0020 abc def 0001 0002 deadbeef 01234567 89abcdef fedcba98 0
1 0030 800 321 0006 0007 00000001 00000002 00000004 00000008 0
3 0030 321 654 0006 0007 00000001 00000002 00000004 00000008 0
2 0040 0f0 f0f ffff 0000 76543210 fedcba98 80000000 7fffffff 0
0 0040 f0f 0f0 fffe ffff 76543210 fedcba98 80000000 7fffffff 0
0 0040 0f0 aaa ffff 0000 76543210 fedcba98 80000000 7fffffff 0
2 1234 555 666 00a0 00a1 12345678 9abcdef0 0f1e2d3c 4b5a6978 0
3 1234 666 777 00a0 00a1 12345678 9abcdef0 0f1e2d3c 4b5a6978 0

// ==== flist.f ====
+incdir+include
design/ivTypesPkg.sv
design/ivCommandPkg.sv
design/macEngine.sv
design/commandDecoder.sv
design/storeSequencer.sv
design/loadChecker.sv
design/integrityVerifier.sv
tests/tbIntegrityVerifier.sv

// ==== Bender.yml ====
package:
  name: integrity_verifier

export_include_dirs:
  - include

sources:
  - design/ivTypesPkg.sv
  - design/ivCommandPkg.sv
  - design/macEngine.sv
  - design/commandDecoder.sv
  - design/storeSequencer.sv
  - design/loadChecker.sv
  - design/integrityVerifier.sv
  - target: test
    files:
      - tests/tbIntegrityVerifier.sv
